/* source/aether_params.svh */
`ifndef AETHER_PARAMS_SVH
`define AETHER_PARAMS_SVH

// Data widths
`define AETHER_PIXEL_WIDTH 8   // Activations and weights
`define AETHER_WORD_WIDTH 16   // Host and buffer word
`define AETHER_ACC_WIDTH 20    // Nine 8x8 products without overflow

// ----------------------------------------------------------------------
// Geometry
// ----------------------------------------------------------------------
`define AETHER_KERNEL_SIZE 3
`define AETHER_MATRIX_SIZE 8
`define AETHER_BUFFER_WORDS 32 // Two pixels per word

`define AETHER_VERSION 16'h6C00 // Read back by OP_READ_VERSION

`endif

/* source/aether_cmd_pkg.sv */
`default_nettype none

`include "aether_params.svh"

// Host command interface types
package aether_cmd_pkg;

  // Instruction encoding on instruction_i
  typedef enum logic [3:0] {
    OP_NOP          = 4'h0,
    OP_LOAD_WEIGHT  = 4'h1, // param_1 = kernel index, param_2 low byte = weight
    OP_LOAD_START   = 4'h2, // Rewind buffer write address
    OP_LOAD_DATA    = 4'h3, // param_2 = two packed pixels
    OP_RUN_CONV     = 4'h4,
    OP_READ_VERSION = 4'h5,
    OP_READ_STATUS  = 4'h6  // Bit 0 busy, bit 1 interrupt
  } opcode_e;

  typedef logic [3:0] param1_t;
  typedef logic [`AETHER_WORD_WIDTH-1:0] word_t;

  // Buffer word address, wraps at the buffer depth
  typedef logic [$clog2(`AETHER_BUFFER_WORDS)-1:0] buf_addr_t;

endpackage

`default_nettype wire

/* source/aether_conv_pkg.sv */
`default_nettype none

`include "aether_params.svh"

// Convolution datapath types
package aether_conv_pkg;

  typedef logic signed [`AETHER_PIXEL_WIDTH-1:0] pixel_t;  // Activation
  typedef logic signed [`AETHER_PIXEL_WIDTH-1:0] weight_t; // Kernel tap
  typedef logic signed [`AETHER_ACC_WIDTH-1:0] acc_t;      // Window sum

  // Row or column inside the matrix
  typedef logic [$clog2(`AETHER_MATRIX_SIZE)-1:0] coord_t;

  // Convolver stream tracking
  typedef enum logic {
    CONV_IDLE,
    CONV_STREAM
  } conv_state_e;

endpackage

`default_nettype wire

/* source/aether_decoder.sv */
`default_nettype none

`include "aether_params.svh"

module aether_decoder (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     cmd_valid_i,   // Single-cycle strobe
  input  aether_cmd_pkg::opcode_e  instruction_i,
  input  aether_cmd_pkg::param1_t  param_1_i,
  input  aether_cmd_pkg::word_t    param_2_i,
  input  logic                     conv_done_i,
  output aether_cmd_pkg::word_t    data_o,
  output logic                     interrupt_o,
  output logic                     wr_en_o,
  output aether_cmd_pkg::buf_addr_t wr_addr_o,
  output aether_cmd_pkg::word_t    wr_data_o,
  output logic                     run_strobe_o,
  output aether_conv_pkg::weight_t weights_o [`AETHER_KERNEL_SIZE*`AETHER_KERNEL_SIZE]
);
  import aether_cmd_pkg::*;
  import aether_conv_pkg::*;

  localparam int KERNEL_TAPS = `AETHER_KERNEL_SIZE * `AETHER_KERNEL_SIZE;

  logic      busy_q;     // RUN accepted, conv_done not yet seen
  buf_addr_t next_addr_q; // Next buffer word to write
  logic      is_read;
  logic      accept;
  logic      load_weight;
  logic      load_data;
  word_t     status;
  weight_t   new_weight;

  // ----------------------------------------------------------------------
  // Command acceptance
  // ----------------------------------------------------------------------
  assign is_read = (instruction_i == OP_READ_VERSION) || (instruction_i == OP_READ_STATUS);
  assign accept  = cmd_valid_i && (!busy_q || is_read); // Reads never blocked

  assign load_weight = accept && (instruction_i == OP_LOAD_WEIGHT);
  assign load_data   = accept && (instruction_i == OP_LOAD_DATA);

  assign new_weight = weight_t'(param_2_i[`AETHER_PIXEL_WIDTH-1:0]); // Low byte only
  assign status     = {{(`AETHER_WORD_WIDTH-2){1'b0}}, interrupt_o, busy_q};

  // Control state and strobes
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_en_o      <= 1'b0;
      run_strobe_o <= 1'b0;
      busy_q       <= 1'b0;
      interrupt_o  <= 1'b0;
      next_addr_q  <= '0;
      data_o       <= '0;
    end
    else
    begin
      wr_en_o      <= 1'b0; // Strobes last one cycle
      run_strobe_o <= 1'b0;

      // Run finished
      if (conv_done_i)
      begin
        busy_q      <= 1'b0;
        interrupt_o <= 1'b1;
      end

      if (accept)
      begin
        case (instruction_i)
          OP_LOAD_START:
          begin
            next_addr_q <= '0;
            interrupt_o <= 1'b0;
          end
          OP_LOAD_DATA:
          begin
            wr_en_o     <= 1'b1;
            next_addr_q <= next_addr_q + 1'b1; // Wraps at buffer end
          end
          OP_RUN_CONV:
          begin
            run_strobe_o <= 1'b1;
            busy_q       <= 1'b1;
            interrupt_o  <= 1'b0;
          end
          OP_READ_VERSION: data_o <= `AETHER_VERSION;
          OP_READ_STATUS:  data_o <= status;  // Flags as they stand now
          default:         data_o <= data_o;  // NOP and weight loads
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // Write payload and kernel weights
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (load_data)
    begin
      wr_addr_o <= next_addr_q;
      wr_data_o <= param_2_i;
    end
    // Row-major kernel where an index above 8 matches nothing
    for (int k = 0; k < KERNEL_TAPS; k++)
    begin
      if (load_weight && (param_1_i == param1_t'(k)))
        weights_o[k] <= new_weight;
    end
  end

  // Completion only ever arrives while a run is pending
  a_done_while_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    conv_done_i |-> busy_q);

endmodule

`default_nettype wire

/* source/aether_input_buffer.sv */
`default_nettype none

`include "aether_params.svh"

module aether_input_buffer (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      wr_en_i,
  input  aether_cmd_pkg::buf_addr_t wr_addr_i,
  input  aether_cmd_pkg::word_t     wr_data_i,
  input  logic                      run_strobe_i, // Start streaming the matrix
  output logic                      pixel_valid_o,
  output aether_conv_pkg::pixel_t   pixel_o
);
  import aether_cmd_pkg::*;
  import aether_conv_pkg::*;

  localparam int DEPTH = `AETHER_BUFFER_WORDS;
  localparam int PW    = `AETHER_PIXEL_WIDTH;

  word_t     mem [DEPTH];
  word_t     rd_word_q;   // Synchronous read data
  buf_addr_t rd_addr_q;
  logic      reading_q;   // Reader active
  logic      byte_sel_q;  // 0 low byte, 1 high byte
  logic      high_q;      // Byte select aligned with rd_word_q
  logic      last_read;

  // High byte of the final word ends the stream
  assign last_read = reading_q && byte_sel_q && (rd_addr_q == buf_addr_t'(DEPTH - 1));

  // ----------------------------------------------------------------------
  // Memory with one write port and one read port
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i)
  begin
    if (wr_en_i)
      mem[wr_addr_i] <= wr_data_i;
    rd_word_q <= mem[rd_addr_q]; // Each word read once per byte
  end

  // Reader sequencing
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      reading_q     <= 1'b0;
      rd_addr_q     <= '0;
      byte_sel_q    <= 1'b0;
      high_q        <= 1'b0;
      pixel_valid_o <= 1'b0;
    end
    else
    begin
      if (run_strobe_i)
      begin
        reading_q  <= 1'b1;
        rd_addr_q  <= '0;
        byte_sel_q <= 1'b0;
      end
      else if (reading_q)
      begin
        byte_sel_q <= ~byte_sel_q;
        if (byte_sel_q)
          rd_addr_q <= rd_addr_q + 1'b1; // Next word after the high byte
        if (last_read)
          reading_q <= 1'b0;             // Stops by itself after 64 pixels
      end
      pixel_valid_o <= reading_q;
      high_q        <= byte_sel_q;
    end
  end

  // Unpack with the low byte first
  assign pixel_o = high_q ? pixel_t'(rd_word_q[2*PW-1:PW]) : pixel_t'(rd_word_q[PW-1:0]);

  // Read address only climbs while streaming and never wraps to word 0
  a_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reading_q |=> (!reading_q || (rd_addr_q >= $past(rd_addr_q))));

endmodule

`default_nettype wire

/* source/aether_convolver.sv */
`default_nettype none

`include "aether_params.svh"

module aether_convolver (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     pixel_valid_i, // One pixel per cycle in raster order
  input  aether_conv_pkg::pixel_t  pixel_i,
  input  aether_conv_pkg::weight_t weights_i [`AETHER_KERNEL_SIZE*`AETHER_KERNEL_SIZE],
  output logic                     result_valid_o,
  output aether_conv_pkg::acc_t    result_o,
  output logic                     conv_done_o      // One cycle after the last pixel
);
  import aether_conv_pkg::*;

  localparam int KSIZE = `AETHER_KERNEL_SIZE;
  localparam int MSIZE = `AETHER_MATRIX_SIZE;
  localparam int SPAN  = (KSIZE - 1) * MSIZE + KSIZE; // Newest pixel back to top-left

  conv_state_e state_q;
  coord_t      row_q;        // Position of pixel_i
  coord_t      col_q;
  pixel_t      line_q [SPAN-1]; // Two rows plus two pixels of history
  pixel_t      taps [SPAN];     // History plus the incoming pixel
  acc_t        window_sum;
  logic        window_done;
  logic        last_pixel;

  // ----------------------------------------------------------------------
  // Window taps and sum
  // ----------------------------------------------------------------------
  always_comb
  begin
    taps[0] = pixel_i; // Bottom-right of the window
    for (int k = 1; k < SPAN; k++)
    begin
      taps[k] = line_q[k-1];
    end
  end

  // Weight 0 pairs with the top-left pixel as the oldest tap
  always_comb
  begin
    window_sum = '0;
    for (int kr = 0; kr < KSIZE; kr++)
    begin
      for (int kc = 0; kc < KSIZE; kc++)
      begin
        window_sum = window_sum
          + acc_t'(taps[(KSIZE-1-kr)*MSIZE + (KSIZE-1-kc)]) * acc_t'(weights_i[kr*KSIZE+kc]);
      end
    end
  end

  assign window_done = pixel_valid_i && (row_q >= coord_t'(KSIZE - 1))
                       && (col_q >= coord_t'(KSIZE - 1));
  assign last_pixel  = pixel_valid_i && (row_q == coord_t'(MSIZE - 1))
                       && (col_q == coord_t'(MSIZE - 1));

  // ----------------------------------------------------------------------
  // Stream tracking
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_q        <= CONV_IDLE;
      row_q          <= '0;
      col_q          <= '0;
      result_valid_o <= 1'b0;
      conv_done_o    <= 1'b0;
    end
    else
    begin
      result_valid_o <= window_done;
      conv_done_o    <= (state_q == CONV_STREAM) && last_pixel;

      if (pixel_valid_i)
      begin
        if (col_q == coord_t'(MSIZE - 1))
        begin
          col_q <= '0;
          row_q <= row_q + 1'b1; // Back to zero after the last row
        end
        else
          col_q <= col_q + 1'b1;
      end

      case (state_q)
        CONV_IDLE:   if (pixel_valid_i) state_q <= CONV_STREAM;
        CONV_STREAM: if (last_pixel) state_q <= CONV_IDLE;
        default:     state_q <= CONV_IDLE;
      endcase
    end
  end

  // Pixel history and result register
  always_ff @(posedge clk_i)
  begin
    if (pixel_valid_i)
    begin
      line_q[0] <= pixel_i;
      for (int k = 1; k < SPAN - 1; k++)
      begin
        line_q[k] <= line_q[k-1];
      end
    end
    if (window_done)
      result_o <= window_sum;
  end

  // Stream runs without gaps from its first pixel to its last
  a_stream_no_gap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (state_q == CONV_STREAM) |-> pixel_valid_i);

endmodule

`default_nettype wire

/* source/aether_engine.sv */
`default_nettype none

`include "aether_params.svh"

module aether_engine (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_valid_i,
  input  aether_cmd_pkg::opcode_e instruction_i,
  input  aether_cmd_pkg::param1_t param_1_i,
  input  aether_cmd_pkg::word_t   param_2_i,
  output aether_cmd_pkg::word_t   data_o,        // Version or status
  output logic                    interrupt_o,   // Run finished
  output logic                    result_valid_o,
  output aether_conv_pkg::acc_t   result_o
);

  // ----------------------------------------------------------------------
  // Internal wiring
  // ----------------------------------------------------------------------
  logic                      wr_en;
  aether_cmd_pkg::buf_addr_t wr_addr;
  aether_cmd_pkg::word_t     wr_data;
  logic                      run_strobe;
  logic                      pixel_valid;
  aether_conv_pkg::pixel_t   pixel;
  aether_conv_pkg::weight_t  weights [`AETHER_KERNEL_SIZE*`AETHER_KERNEL_SIZE];
  logic                      conv_done;

  // Command decode, weights, flags
  aether_decoder u_decoder (
    .clk_i,
    .rst_n_i,
    .cmd_valid_i,
    .instruction_i,
    .param_1_i,
    .param_2_i,
    .conv_done_i  (conv_done),
    .data_o,
    .interrupt_o,
    .wr_en_o      (wr_en),
    .wr_addr_o    (wr_addr),
    .wr_data_o    (wr_data),
    .run_strobe_o (run_strobe),
    .weights_o    (weights)
  );

  // Matrix store and pixel stream
  aether_input_buffer u_input_buffer (
    .clk_i,
    .rst_n_i,
    .wr_en_i       (wr_en),
    .wr_addr_i     (wr_addr),
    .wr_data_i     (wr_data),
    .run_strobe_i  (run_strobe),
    .pixel_valid_o (pixel_valid),
    .pixel_o       (pixel)
  );

  aether_convolver u_convolver (
    .clk_i,
    .rst_n_i,
    .pixel_valid_i (pixel_valid),
    .pixel_i       (pixel),
    .weights_i     (weights),
    .result_valid_o,
    .result_o,
    .conv_done_o   (conv_done) // Back to the decoder
  );

endmodule

`default_nettype wire

/* bench/tb_aether_engine.sv */
`default_nettype none

module tb_aether_engine;
  import aether_cmd_pkg::*;
  import aether_conv_pkg::*;

  localparam int HALF_PERIOD     = 10;
  localparam int DRIVE_DELAY     = 2;    // Inputs move after the edge
  localparam int RESET_CYCLES    = 4;
  localparam int NUM_SETS        = 2;
  localparam int TAPS            = 9;
  localparam int WORDS           = 32;
  localparam int RESULTS         = 36;   // 6x6 valid windows
  localparam int NUM_TESTS       = 4;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int RUN_LIMIT       = 200;  // RUN to interrupt with margin

  logic    clk;
  logic    rst_n;
  logic    cmd_valid;
  opcode_e instruction;
  param1_t param_1;
  word_t   param_2;
  word_t   data;
  logic    interrupt;
  logic    result_valid;
  acc_t    result;

  int   weight_tab [NUM_SETS*TAPS];
  int   word_tab   [NUM_SETS*WORDS];
  int   expect_tab [NUM_SETS*RESULTS];
  acc_t got_q [$];      // Results in arrival order
  int   error_count;
  int   test_count;
  int   test_fail_count;
  int   errors_at_start;

  aether_engine u_aether_engine (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .cmd_valid_i    (cmd_valid),
    .instruction_i  (instruction),
    .param_1_i      (param_1),
    .param_2_i      (param_2),
    .data_o         (data),
    .interrupt_o    (interrupt),
    .result_valid_o (result_valid),
    .result_o       (result)
  );

  initial clk = 1'b0;
  always #HALF_PERIOD clk = ~clk;

  // Outputs settle long before the falling edge
  always @(negedge clk)
  begin
    if (rst_n && result_valid)
      got_q.push_back(result);
  end

  initial
  begin
    #(NUM_TESTS * CYCLES_PER_TEST * 2 * HALF_PERIOD);
    $display("Watchdog expired before all tests finished");
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
  endtask

  // Random idle gap, then a one-cycle command strobe
  task automatic send_cmd(input opcode_e op, input param1_t p1, input word_t p2);
    wait_cycles(int'($urandom % 4));
    cmd_valid   = 1'b1;
    instruction = op;
    param_1     = p1;
    param_2     = p2;
    wait_cycles(1);            // Accepted at this edge
    cmd_valid   = 1'b0;
    instruction = OP_NOP;
    param_1     = '0;
    param_2     = '0;
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("MISMATCH %s expected %0h got %0h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic begin_test();
    test_count++;
    errors_at_start = error_count;
  endtask

  task automatic end_test(input string name);
    if (error_count == errors_at_start)
      $display("test %0d %s: pass", test_count, name);
    else
    begin
      $display("test %0d %s: FAIL, %0d errors", test_count, name,
               error_count - errors_at_start);
      test_fail_count++;
    end
  endtask

  // Tagged lines with # for comments
  task automatic read_stimulus();
    int    fd;
    int    n_w;
    int    n_d;
    int    n_e;
    int    got;
    int    v [9];
    string line;
    n_w = 0;
    n_d = 0;
    n_e = 0;
    fd  = $fopen("bench/aether_stimulus.txt", "r");
    if (fd == 0)
    begin
      $display("Cannot open bench/aether_stimulus.txt");
      error_count++;
    end
    else
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 0)
        begin
          case (line[0])
            "W":
            begin
              got = $sscanf(line, "W %h %h %h %h %h %h %h %h %h",
                            v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8]);
              for (int k = 0; k < TAPS; k++)
                if (got == TAPS && n_w + k < NUM_SETS*TAPS) weight_tab[n_w+k] = v[k];
              n_w += got;
            end
            "D":
            begin
              got = $sscanf(line, "D %h %h %h %h", v[0], v[1], v[2], v[3]);
              for (int k = 0; k < 4; k++)
                if (got == 4 && n_d + k < NUM_SETS*WORDS) word_tab[n_d+k] = v[k];
              n_d += got;
            end
            "E":
            begin
              got = $sscanf(line, "E %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5]);
              for (int k = 0; k < 6; k++)
                if (got == 6 && n_e + k < NUM_SETS*RESULTS) expect_tab[n_e+k] = v[k];
              n_e += got;
            end
            default: ;   // Comments and blank lines
          endcase
        end
      end
      $fclose(fd);
      if (n_w != NUM_SETS*TAPS || n_d != NUM_SETS*WORDS || n_e != NUM_SETS*RESULTS)
      begin
        $display("Stimulus file holds %0d weights, %0d words, %0d sums, not the full sets",
                 n_w, n_d, n_e);
        error_count++;
      end
    end
  endtask

  // Weights, rewind, then the whole matrix
  task automatic load_set(input int s);
    for (int k = 0; k < TAPS; k++)
      send_cmd(OP_LOAD_WEIGHT, param1_t'(k), word_t'(weight_tab[s*TAPS+k] & 'hFF));
    send_cmd(OP_LOAD_START, '0, '0);
    for (int w = 0; w < WORDS; w++)
      send_cmd(OP_LOAD_DATA, '0, word_t'(word_tab[s*WORDS+w]));
  endtask

  task automatic run_and_check(input int s);
    int waited;
    int n;
    got_q.delete();
    send_cmd(OP_RUN_CONV, '0, '0);
    send_cmd(OP_LOAD_WEIGHT, '0, 16'h007F);  // Ignored while busy so tap 0 keeps its value
    waited = 0;
    while (!interrupt && waited < RUN_LIMIT)
    begin
      wait_cycles(1);
      waited++;
    end
    if (!interrupt)
    begin
      $display("No interrupt within %0d cycles of the run command", RUN_LIMIT);
      error_count++;
    end
    wait_cycles(2);                          // Catch any stray result
    if (got_q.size() < RESULTS)
    begin
      $display("Missing results: got %0d of %0d", got_q.size(), RESULTS);
      error_count++;
    end
    else if (got_q.size() > RESULTS)
    begin
      $display("Extra results: got %0d, expected %0d", got_q.size(), RESULTS);
      error_count++;
    end
    n = (got_q.size() < RESULTS) ? got_q.size() : RESULTS;
    for (int k = 0; k < n; k++)
      compare_value($sformatf("result_o[%0d]", k),
                    expect_tab[s*RESULTS+k] & 32'hFFFFF, {12'h000, got_q[k]});
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(80052));
    error_count     = 0;
    test_count      = 0;
    test_fail_count = 0;
    errors_at_start = 0;
    rst_n           = 1'b0;
    cmd_valid       = 1'b0;
    instruction     = OP_NOP;
    param_1         = '0;
    param_2         = '0;
    read_stimulus();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    wait_cycles(2);

    begin_test();
    send_cmd(OP_READ_VERSION, '0, '0);
    compare_value("data_o", 32'h0000_6C00, {16'h0000, data});
    end_test("version read");

    begin_test();
    load_set(0);
    run_and_check(0);
    end_test("set 1 convolution, weight load while busy");

    // Run over with flags still standing
    begin_test();
    compare_value("interrupt_o", 32'd1, {31'h0, interrupt});
    send_cmd(OP_READ_STATUS, '0, '0);
    compare_value("data_o", 32'h2, {16'h0000, data});
    send_cmd(OP_LOAD_START, '0, '0);
    compare_value("interrupt_o", 32'd0, {31'h0, interrupt});
    end_test("completion status and interrupt clear");

    // Five stray words, then load_set rewinds before the real matrix
    begin_test();
    for (int w = 0; w < 5; w++)
      send_cmd(OP_LOAD_DATA, '0, word_t'(16'hA5A0 + w));
    load_set(1);
    run_and_check(1);
    end_test("set 2 after partial load and restart");

    $display("tests %0d, passed %0d, failed %0d, errors %0d", test_count,
             test_count - test_fail_count, test_fail_count, error_count);
    if (error_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* aether_engine.f */
+incdir+source
source/aether_cmd_pkg.sv
source/aether_conv_pkg.sv
source/aether_decoder.sv
source/aether_input_buffer.sv
source/aether_convolver.sv
source/aether_engine.sv
bench/tb_aether_engine.sv

/* Makefile */
# Verilator simulation of the convolution engine testbench

VERILATOR ?= verilator
TOP       ?= tb_aether_engine
FILELIST  ?= aether_engine.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* bench/aether_stimulus.txt */
# W: nine kernel weights, row-major; D: one matrix row as four words, low byte first
# E: six expected window sums of one output row, 20-bit two's complement
W 01 02 FF 03 00 FE 04 FD 05
D 0100 0302 0504 0706
D 0908 0B0A 0D0C 0F0E
D 1110 1312 1514 1716
D 1918 1B1A 1D1C 1F1E
D 2120 2322 2524 2726
D 2928 2B2A 2D2C 2F2E
D 3130 3332 3534 3736
D 3938 3B3A 3D3C 3F3E
E 6B 74 7D 86 8F 98
E B3 BC C5 CE D7 E0
E FB 104 10D 116 11F 128
E 143 14C 155 15E 167 170
E 18B 194 19D 1A6 1AF 1B8
E 1D3 1DC 1E5 1EE 1F7 200
W FE 03 01 00 FF 04 02 FC 01
D FD05 0109 050D 0911
D 04F8 08FC 0C00 1004
D F7FF FB03 FF07 030B
D FEF2 02F6 06FA 0AFE
D F1F9 F5FD F901 FD05
D F8EC FCF0 00F4 04F8
D EBF3 EFF7 F3FB F7FF
D F2E6 F6EA FAEE FEF2
E 7 23 17 33 27 43
E F 3 1F 13 2F 23
E FFFEF B FFFFF 1B F 2B
E FFFF7 FFFEB 7 FFFFB 17 B
E FFFD7 FFFF3 FFFE7 3 FFFF7 13
E FFFDF FFFD3 FFFEF FFFE3 FFFFF FFFF3
